/* rtl/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Horizontal or vertical screen position, also used for scroll offsets
    typedef logic [8:0] coord_t;

    // Tile map word: [15:14] palette select, [9:0] tile number
    typedef logic [15:0] tile_code_t;

    // Eight 4-bit pixels per ROM word, pixel 0 in the low nibble
    typedef logic [31:0] gfx_row_t;

    // Palette select in the upper nibble, colour in the lower one
    // Colour 0 is transparent
    typedef logic [7:0] layer_pxl_t;

    // 5:5:5 RGB, red on top
    typedef logic [15:0] pal_entry_t;

    // CPU register map
    localparam logic [7:0] REG_HPOS1      = 8'd0;
    localparam logic [7:0] REG_VPOS1      = 8'd1;
    localparam logic [7:0] REG_HPOS2      = 8'd2;
    localparam logic [7:0] REG_VPOS2      = 8'd3;
    localparam logic [7:0] REG_LAYER_CTRL = 8'd4;

    // Everything from here up goes to the palette
    localparam logic [7:0] PAL_BASE       = 8'h80;

    // Pixel enables from layer position input to layer pixel output
    localparam int LAYER_LATENCY = 3;

endpackage

`default_nettype wire

/* rtl/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_TOTAL  = 80,
    parameter int H_ACTIVE = 64,
    parameter int V_TOTAL  = 40,
    parameter int V_ACTIVE = 32
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               pxl_cen,
    output video_pkg::coord_t hdump,
    output video_pkg::coord_t vrender,
    output logic              hs,
    output logic              vs,
    output logic              hb,
    output logic              vb
);
    import video_pkg::*;

    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT    = coord_t'(H_ACTIVE);
    localparam coord_t V_ACT    = coord_t'(V_ACTIVE);
    localparam coord_t HS_START = coord_t'(H_ACTIVE + 4);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + 12);
    localparam coord_t VS_LINE  = coord_t'(V_ACTIVE + 2);

    coord_t h_nxt;
    coord_t v_nxt;

    // Next raster position, shared by the counters and the flags
    always_comb begin
        h_nxt = hdump + 9'd1;
        v_nxt = vrender;
        if (hdump == H_LAST) begin
            h_nxt = '0;
            if (vrender == V_LAST) begin
                v_nxt = '0;
            end else begin
                v_nxt = vrender + 9'd1;
            end
        end
    end

    // Counters start on the last pixel of the last line, so the first
    // enable after reset lands on the top left corner
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump   <= H_LAST;
            vrender <= V_LAST;
            hs      <= 1'b0;
            vs      <= 1'b0;
            hb      <= 1'b1;
            vb      <= 1'b1;
        end else if (pxl_cen) begin
            hdump   <= h_nxt;
            vrender <= v_nxt;
            // Flags follow the counter values they are registered with
            hb      <= h_nxt >= H_ACT;
            hs      <= (h_nxt >= HS_START) && (h_nxt < HS_END);
            vb      <= v_nxt >= V_ACT;
            vs      <= v_nxt == VS_LINE;
        end
    end

endmodule

`default_nettype wire

/* rtl/ppu_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cpu_cs,
    input  wire                    cpu_we,
    input  wire  [7:0]             addr,
    input  wire  [15:0]            cpu_din,
    output logic [15:0]            mmr_dout,
    output video_pkg::coord_t      hpos1,
    output video_pkg::coord_t      vpos1,
    output video_pkg::coord_t      hpos2,
    output video_pkg::coord_t      vpos2,
    output logic [2:0]             layer_ctrl,
    output logic                   pal_we,
    output logic [6:0]             pal_addr,
    output video_pkg::pal_entry_t  pal_data
);
    import video_pkg::*;

    logic        wr;
    logic        rd;
    logic        pal_sel;
    logic [15:0] rd_val;

    assign wr      = cpu_cs && cpu_we;
    assign rd      = cpu_cs && !cpu_we;
    assign pal_sel = addr >= PAL_BASE;

    // Palette writes pass straight through during the CPU cycle
    assign pal_we   = wr && pal_sel;
    assign pal_addr = 7'(addr - PAL_BASE);
    assign pal_data = pal_entry_t'(cpu_din);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hpos1      <= '0;
            vpos1      <= '0;
            hpos2      <= '0;
            vpos2      <= '0;
            layer_ctrl <= '0;
        end else if (wr && !pal_sel) begin
            case (addr)
                REG_HPOS1:      hpos1      <= cpu_din[8:0];
                REG_VPOS1:      vpos1      <= cpu_din[8:0];
                REG_HPOS2:      hpos2      <= cpu_din[8:0];
                REG_VPOS2:      vpos2      <= cpu_din[8:0];
                REG_LAYER_CTRL: layer_ctrl <= cpu_din[2:0];
                default: ;
            endcase
        end
    end

    // Readback mux, palette and unmapped addresses read as zero
    always_comb begin
        case (addr)
            REG_HPOS1:      rd_val = 16'(hpos1);
            REG_VPOS1:      rd_val = 16'(vpos1);
            REG_HPOS2:      rd_val = 16'(hpos2);
            REG_VPOS2:      rd_val = 16'(vpos2);
            REG_LAYER_CTRL: rd_val = 16'(layer_ctrl);
            default:        rd_val = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mmr_dout <= '0;
        end else if (rd) begin
            mmr_dout <= rd_val;
        end
    end

endmodule

`default_nettype wire

/* rtl/scroll_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll_layer #(
    parameter int TILE_SHIFT = 3
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    pxl_cen,
    input  wire video_pkg::coord_t hdump,
    input  wire video_pkg::coord_t vrender,
    input  wire video_pkg::coord_t hpos,
    input  wire video_pkg::coord_t vpos,
    output logic [11:0]            map_addr,
    input  wire video_pkg::tile_code_t map_data,
    output logic [15:0]            gfx_addr,
    input  wire video_pkg::gfx_row_t gfx_data,
    output video_pkg::layer_pxl_t  pxl
);
    import video_pkg::*;

    localparam int TILE_SIZE  = 1 << TILE_SHIFT;
    // Number of 8-pixel halves selector bits, zero for 8x8 tiles
    localparam int HALF_SHIFT = TILE_SHIFT - 3;

    coord_t      hscr;
    coord_t      vscr;
    coord_t      htile;
    coord_t      vtile;
    coord_t      hfine;
    coord_t      vfine;
    coord_t      half_s1;
    coord_t      vfine_s1;
    logic [1:0]  pal_s2;
    logic [15:0] gfx_nxt;
    logic [3:0]  nibble;

    // Fine column travels alongside the fetches
    logic [2:0]  col_dly [LAYER_LATENCY-1];

    // Scrolled position wraps at 512
    assign hscr  = hdump + hpos;
    assign vscr  = vrender + vpos;
    assign htile = hscr >> TILE_SHIFT;
    assign vtile = vscr >> TILE_SHIFT;
    assign hfine = hscr & coord_t'(TILE_SIZE - 1);
    assign vfine = vscr & coord_t'(TILE_SIZE - 1);

    // ROM word layout is tile, fine row, then half for 16-pixel tiles
    assign gfx_nxt = (16'(map_data[9:0]) << (TILE_SHIFT + HALF_SHIFT))
                   | (16'(vfine_s1) << HALF_SHIFT)
                   | 16'(half_s1);

    assign nibble = gfx_data[{col_dly[LAYER_LATENCY-2], 2'b00} +: 4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_addr <= '0;
            half_s1  <= '0;
            vfine_s1 <= '0;
            gfx_addr <= '0;
            pal_s2   <= '0;
            pxl      <= '0;
            for (int i = 0; i < LAYER_LATENCY - 1; i++) begin
                col_dly[i] <= '0;
            end
        end else if (pxl_cen) begin
            // Stage 1: map lookup, 64 tiles per row
            map_addr   <= {vtile[5:0], htile[5:0]};
            half_s1    <= hfine >> 3;
            vfine_s1   <= vfine;
            col_dly[0] <= hfine[2:0];
            for (int i = 1; i < LAYER_LATENCY - 1; i++) begin
                col_dly[i] <= col_dly[i-1];
            end
            // Stage 2: tile code is back, ask for the pixel row
            gfx_addr   <= gfx_nxt;
            pal_s2     <= map_data[15:14];
            // Stage 3: pick the pixel out of the row
            pxl        <= layer_pxl_t'({2'b00, pal_s2, nibble});
        end
    end

endmodule

`default_nettype wire

/* rtl/colmix.sv */
`timescale 1ns/1ps
`default_nettype none

module colmix (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        pxl_cen,
    input  wire                        hb,
    input  wire                        vb,
    input  wire  [2:0]                 layer_ctrl,
    input  wire video_pkg::layer_pxl_t pxl1,
    input  wire video_pkg::layer_pxl_t pxl2,
    input  wire                        pal_we,
    input  wire  [6:0]                 pal_addr,
    input  wire video_pkg::pal_entry_t pal_data,
    output logic                       lhbl_dly,
    output logic                       lvbl_dly,
    output logic [7:0]                 red,
    output logic [7:0]                 green,
    output logic [7:0]                 blue
);
    import video_pkg::*;

    logic [LAYER_LATENCY-1:0] hb_sr;
    logic [LAYER_LATENCY-1:0] vb_sr;
    pal_entry_t               pal_ram [128];
    pal_entry_t               pal_rd;
    logic                     l1_opaque;
    logic                     l2_opaque;
    logic [6:0]               pal_idx;
    logic                     blank;

    function automatic logic [7:0] expand5(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    assign l1_opaque = layer_ctrl[0] && (pxl1[3:0] != 4'd0);
    assign l2_opaque = layer_ctrl[1] && (pxl2[3:0] != 4'd0);

    // Layer 2 wins when it is on top or layer 1 shows nothing
    always_comb begin
        pal_idx = 7'd0;
        if (l2_opaque && (layer_ctrl[2] || !l1_opaque)) begin
            pal_idx = {1'b1, pxl2[5:0]};
        end else if (l1_opaque) begin
            pal_idx = {1'b0, pxl1[5:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_data;
        end
    end

    assign pal_rd = pal_ram[pal_idx];
    assign blank  = hb_sr[LAYER_LATENCY-1] || vb_sr[LAYER_LATENCY-1];

    // Blanking delay matches the layer fetch pipeline
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_sr <= '1;
            vb_sr <= '1;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[LAYER_LATENCY-2:0], hb};
            vb_sr <= {vb_sr[LAYER_LATENCY-2:0], vb};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            lhbl_dly <= !hb_sr[LAYER_LATENCY-1];
            lvbl_dly <= !vb_sr[LAYER_LATENCY-1];
            red      <= blank ? 8'd0 : expand5(pal_rd[14:10]);
            green    <= blank ? 8'd0 : expand5(pal_rd[9:5]);
            blue     <= blank ? 8'd0 : expand5(pal_rd[4:0]);
        end
    end

endmodule

`default_nettype wire

/* rtl/video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_top #(
    parameter int H_TOTAL  = 80,
    parameter int H_ACTIVE = 64,
    parameter int V_TOTAL  = 40,
    parameter int V_ACTIVE = 32
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    // CPU port
    input  wire                          cpu_cs,
    input  wire                          cpu_we,
    input  wire  [7:0]                   addr,
    input  wire  [15:0]                  cpu_din,
    output wire  [15:0]                  mmr_dout,
    // Layer 1 memories
    output wire  [11:0]                  map1_addr,
    input  wire video_pkg::tile_code_t   map1_data,
    output wire  [15:0]                  gfx1_addr,
    input  wire video_pkg::gfx_row_t     gfx1_data,
    // Layer 2 memories
    output wire  [11:0]                  map2_addr,
    input  wire video_pkg::tile_code_t   map2_data,
    output wire  [15:0]                  gfx2_addr,
    input  wire video_pkg::gfx_row_t     gfx2_data,
    // Video
    output wire video_pkg::coord_t       hdump,
    output wire video_pkg::coord_t       vrender,
    output wire                          hs,
    output wire                          vs,
    output wire                          hb,
    output wire                          vb,
    output wire                          lhbl_dly,
    output wire                          lvbl_dly,
    output wire  [7:0]                   red,
    output wire  [7:0]                   green,
    output wire  [7:0]                   blue
);
    import video_pkg::*;

    wire coord_t     hpos1;
    wire coord_t     vpos1;
    wire coord_t     hpos2;
    wire coord_t     vpos2;
    wire [2:0]       layer_ctrl;
    wire             pal_we;
    wire [6:0]       pal_addr;
    wire pal_entry_t pal_data;
    wire layer_pxl_t pxl1;
    wire layer_pxl_t pxl2;

    video_timing #(
        .H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) u_timing (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vrender(vrender), .hs(hs), .vs(vs), .hb(hb), .vb(vb)
    );

    ppu_regs u_regs (
        .clk(clk), .rst(rst), .cpu_cs(cpu_cs), .cpu_we(cpu_we),
        .addr(addr), .cpu_din(cpu_din), .mmr_dout(mmr_dout),
        .hpos1(hpos1), .vpos1(vpos1), .hpos2(hpos2), .vpos2(vpos2),
        .layer_ctrl(layer_ctrl), .pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data)
    );

    // 8x8 tiles
    scroll_layer #(.TILE_SHIFT(3)) u_scr1 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vrender(vrender), .hpos(hpos1), .vpos(vpos1),
        .map_addr(map1_addr), .map_data(map1_data),
        .gfx_addr(gfx1_addr), .gfx_data(gfx1_data), .pxl(pxl1)
    );

    // 16x16 tiles
    scroll_layer #(.TILE_SHIFT(4)) u_scr2 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vrender(vrender), .hpos(hpos2), .vpos(vpos2),
        .map_addr(map2_addr), .map_data(map2_data),
        .gfx_addr(gfx2_addr), .gfx_data(gfx2_data), .pxl(pxl2)
    );

    colmix u_colmix (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hb(hb), .vb(vb),
        .layer_ctrl(layer_ctrl), .pxl1(pxl1), .pxl2(pxl2),
        .pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
        .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly),
        .red(red), .green(green), .blue(blue)
    );

endmodule

`default_nettype wire

/* tb/video_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module video_chk #(
    parameter int H_TOTAL  = 80,
    parameter int H_ACTIVE = 64,
    parameter int V_TOTAL  = 40,
    parameter int V_ACTIVE = 32
) (
    input wire                    clk,
    input wire                    rst,
    input wire                    pxl_cen,
    input wire video_pkg::coord_t hdump,
    input wire video_pkg::coord_t vrender,
    input wire                    hs,
    input wire                    vs,
    input wire                    hb,
    input wire                    vb,
    input wire                    lhbl_dly,
    input wire                    lvbl_dly,
    input wire [7:0]              red,
    input wire [7:0]              green,
    input wire [7:0]              blue
);
    import video_pkg::*;

    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT    = coord_t'(H_ACTIVE);
    localparam coord_t V_ACT    = coord_t'(V_ACTIVE);
    localparam coord_t HS_START = coord_t'(H_ACTIVE + 4);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + 12);
    localparam coord_t VS_LINE  = coord_t'(V_ACTIVE + 2);

    int unsigned fail_count = 0;

    a_h_range: assert property (@(posedge clk) disable iff (rst)
        (hdump <= H_LAST) && (vrender <= V_LAST))
    else begin
        fail_count++;
        $error("Raster counter out of range");
    end

    // One step per pixel enable, wrapping at the end of the line
    a_h_step: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> hdump == (($past(hdump) == H_LAST) ? 9'd0 : $past(hdump) + 9'd1))
    else begin
        fail_count++;
        $error("hdump did not advance by one on a pixel enable");
    end

    a_blank_flags: assert property (@(posedge clk) disable iff (rst)
        (hb == (hdump >= H_ACT)) && (vb == (vrender >= V_ACT)))
    else begin
        fail_count++;
        $error("hb or vb does not follow the active area");
    end

    // Eight pixels wide since hdump moves once per enable
    a_hsync: assert property (@(posedge clk) disable iff (rst)
        hs == ((hdump >= HS_START) && (hdump < HS_END)))
    else begin
        fail_count++;
        $error("hs outside its eight pixel window");
    end

    // Single sync line per frame
    a_vsync: assert property (@(posedge clk) disable iff (rst)
        vs == (vrender == VS_LINE))
    else begin
        fail_count++;
        $error("vs not aligned to its line");
    end

    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        (!lhbl_dly || !lvbl_dly) |-> ({red, green, blue} == 24'd0))
    else begin
        fail_count++;
        $error("Colour output not black during blanking");
    end

endmodule

`default_nettype wire

/* tb/tb_video.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video;
    import video_pkg::*;

    localparam int H_TOTAL    = 80;
    localparam int H_ACTIVE   = 64;
    localparam int V_TOTAL    = 40;
    localparam int V_ACTIVE   = 32;
    localparam int WAIT_LIMIT = 10000;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen = 1'b0;
    logic        cpu_cs;
    logic        cpu_we;
    logic [7:0]  addr;
    logic [15:0] cpu_din;
    wire  [15:0] mmr_dout;
    wire  [11:0] map1_addr;
    wire  [15:0] gfx1_addr;
    wire  [11:0] map2_addr;
    wire  [15:0] gfx2_addr;
    tile_code_t  map1_data = '0;
    gfx_row_t    gfx1_data = '0;
    tile_code_t  map2_data = '0;
    gfx_row_t    gfx2_data = '0;
    logic [15:0] gfx2_addr_q = '0;
    wire coord_t hdump;
    wire coord_t vrender;
    wire         hs;
    wire         vs;
    wire         hb;
    wire         vb;
    wire         lhbl_dly;
    wire         lvbl_dly;
    wire  [7:0]  red;
    wire  [7:0]  green;
    wire  [7:0]  blue;
    wire  [23:0] rgb;

    integer      seed = 32'h2075;
    string       test_name = "reset";
    logic        pix_chk = 1'b0;
    logic        seen_clr = 1'b0;
    logic [23:0] exp_a = '0;
    logic [23:0] exp_b = '0;
    int          seen_a = 0;
    int          seen_b = 0;
    logic [7:0]  reg_addr;
    logic [15:0] wdata;
    logic [15:0] mask;
    pal_entry_t  p_val;
    pal_entry_t  q_val;
    pal_entry_t  r_val;

    // Scroll values last written by the CPU
    coord_t      scr_h1 = '0;
    coord_t      scr_v1 = '0;
    coord_t      scr_h2 = '0;
    coord_t      scr_v2 = '0;

    // Expected memory addresses
    logic [11:0] exp_map1 = '0;
    logic [11:0] exp_map2 = '0;
    logic [15:0] row1 = '0;
    logic [15:0] exp_gfx1 = '0;

    assign rgb = {red, green, blue};

    video_top #(
        .H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) DUT (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .cpu_cs(cpu_cs), .cpu_we(cpu_we), .addr(addr), .cpu_din(cpu_din), .mmr_dout(mmr_dout),
        .map1_addr(map1_addr), .map1_data(map1_data),
        .gfx1_addr(gfx1_addr), .gfx1_data(gfx1_data),
        .map2_addr(map2_addr), .map2_data(map2_data),
        .gfx2_addr(gfx2_addr), .gfx2_data(gfx2_data),
        .hdump(hdump), .vrender(vrender), .hs(hs), .vs(vs), .hb(hb), .vb(vb),
        .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly), .red(red), .green(green), .blue(blue)
    );

    bind video_top video_chk #(
        .H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) u_chk (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hdump(hdump), .vrender(vrender),
        .hs(hs), .vs(vs), .hb(hb), .vb(vb), .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly),
        .red(red), .green(green), .blue(blue)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #1;
        pxl_cen <= !pxl_cen;
    end

    // Layer 1 is tile 0 in palette 1, solid colour 1
    // Layer 2 is tile 0 in palette 2, colour 2 on even ROM words only
    always @(posedge clk) begin
        #1;
        map1_data   <= 16'h4000;
        gfx1_data   <= 32'h1111_1111;
        map2_data   <= 16'h8000;
        gfx2_addr_q <= gfx2_addr;
        gfx2_data   <= gfx2_addr_q[0] ? 32'h0 : 32'h2222_2222;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp)
        else stop_with_failure($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    // 5:5:5 to 8:8:8 by repeating the top bits of each channel
    function automatic logic [23:0] rgb_of(input pal_entry_t p);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = p[14:10];
        g = p[9:5];
        b = p[4:0];
        return {r, r[4:2], g, g[4:2], b, b[4:2]};
    endfunction

    // Row-major 64x64 tile map
    function automatic logic [11:0] map_index(input int shift, input coord_t x,
                                              input coord_t y);
        coord_t tx;
        coord_t ty;
        tx = x >> shift;
        ty = y >> shift;
        return {ty[5:0], tx[5:0]};
    endfunction

    task automatic cpu_write(input logic [7:0] a, input logic [15:0] d);
        cpu_cs  = 1'b1;
        cpu_we  = 1'b1;
        addr    = a;
        cpu_din = d;
        @(posedge clk);
        #1;
        cpu_cs  = 1'b0;
        cpu_we  = 1'b0;
    endtask

    // Register write that also remembers the scroll values
    task automatic write_reg(input logic [7:0] a, input logic [15:0] d);
        cpu_write(a, d);
        case (a)
            REG_HPOS1: scr_h1 = d[8:0];
            REG_VPOS1: scr_v1 = d[8:0];
            REG_HPOS2: scr_h2 = d[8:0];
            REG_VPOS2: scr_v2 = d[8:0];
            default: ;
        endcase
    endtask

    task automatic read_check(input logic [7:0] a, input logic [15:0] exp, input string name);
        cpu_cs = 1'b1;
        cpu_we = 1'b0;
        addr   = a;
        @(posedge clk);
        #1;
        cpu_cs = 1'b0;
        check_value(name, {16'd0, exp}, {16'd0, mmr_dout});
    endtask

    task automatic wait_vs(input logic level);
        int n;
        n = 0;
        while (vs !== level) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure($sformatf("Timed out waiting for vs to become %0b", level));
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    // Starts at a vsync so the pipeline holds no pixels from an older setup
    task automatic check_frame(input string name, input logic [23:0] a, input logic [23:0] b);
        wait_vs(1'b0);
        wait_vs(1'b1);
        test_name = name;
        exp_a     = a;
        exp_b     = b;
        seen_clr  = 1'b1;
        @(posedge clk);
        #1;
        seen_clr  = 1'b0;
        pix_chk   = 1'b1;
        wait_vs(1'b0);
        wait_vs(1'b1);
        pix_chk   = 1'b0;
    endtask

    always @(negedge clk) begin
        if (seen_clr) begin
            seen_a <= 0;
            seen_b <= 0;
        end else if (pix_chk && lhbl_dly && lvbl_dly) begin
            if (rgb == exp_a) seen_a <= seen_a + 1;
            if (rgb == exp_b) seen_b <= seen_b + 1;
        end
    end

    // Map address one enable after the position, layer 1 ROM row one enable later
    always @(posedge clk) begin
        if (pxl_cen) begin
            exp_map1 <= map_index(3, hdump + scr_h1, vrender + scr_v1);
            exp_map2 <= map_index(4, hdump + scr_h2, vrender + scr_v2);
            row1     <= 16'(coord_t'(vrender + scr_v1) & 9'h7);
            exp_gfx1 <= row1;
        end
    end

    always @(negedge clk) begin
        if (pix_chk) begin
            check_value($sformatf("%s map1_addr", test_name),
                        {20'd0, exp_map1}, {20'd0, map1_addr});
            check_value($sformatf("%s map2_addr", test_name),
                        {20'd0, exp_map2}, {20'd0, map2_addr});
            check_value($sformatf("%s gfx1_addr", test_name),
                        {16'd0, exp_gfx1}, {16'd0, gfx1_addr});
        end
    end

    a_active_colour: assert property (@(posedge clk) disable iff (!pix_chk)
        (lhbl_dly && lvbl_dly) |-> ((rgb == exp_a) || (rgb == exp_b)))
    else stop_with_failure($sformatf("FAILED %s: expected %h or %h, actual %h",
                                     test_name, exp_a, exp_b, $sampled(rgb)));

    always @(posedge clk) begin
        if (DUT.u_chk.fail_count != 0) begin
            stop_with_failure("A timing or blanking assertion in video_chk failed");
        end
    end

    initial begin
        rst     = 1'b1;
        cpu_cs  = 1'b0;
        cpu_we  = 1'b0;
        addr    = 8'd0;
        cpu_din = 16'd0;
        repeat (4) @(posedge clk);
        #1;
        check_value("reset flags", 32'h3, {28'd0, hs, vs, hb, vb});
        check_value("reset colour", 32'h0, {8'd0, rgb});
        check_value("reset readback", 32'h0, {16'd0, mmr_dout});
        rst = 1'b0;

        // Random register writes with readback, scroll is 9 bits, control 3
        repeat (4) begin
            for (reg_addr = REG_HPOS1; reg_addr <= REG_LAYER_CTRL; reg_addr++) begin
                wdata = 16'($random(seed));
                mask  = (reg_addr == REG_LAYER_CTRL) ? 16'h0007 : 16'h01FF;
                write_reg(reg_addr, wdata);
                read_check(reg_addr, wdata & mask, $sformatf("readback of register %0d", reg_addr));
            end
        end
        read_check(PAL_BASE + 8'd17, 16'h0, "palette readback");

        p_val = pal_entry_t'($random(seed)) & 16'h7FFF;
        write_reg(REG_LAYER_CTRL, 16'h0000);
        cpu_write(PAL_BASE, p_val);
        check_frame("backdrop", rgb_of(p_val), rgb_of(p_val));

        q_val = pal_entry_t'($random(seed)) & 16'h7FFF;
        cpu_write(PAL_BASE + 8'd17, q_val);
        write_reg(REG_HPOS1, 16'($random(seed)));
        write_reg(REG_VPOS1, 16'($random(seed)));
        write_reg(REG_LAYER_CTRL, 16'h0001);
        check_frame("layer 1 only", rgb_of(q_val), rgb_of(q_val));

        r_val = pal_entry_t'($random(seed)) & 16'h7FFF;
        if (r_val == q_val) r_val = r_val ^ 16'h0001;
        cpu_write(PAL_BASE + 8'd98, r_val);
        write_reg(REG_HPOS2, 16'($random(seed)));
        write_reg(REG_VPOS2, 16'($random(seed)));
        write_reg(REG_LAYER_CTRL, 16'h0007);
        check_frame("layer 2 on top", rgb_of(r_val), rgb_of(q_val));
        assert ((seen_a > 0) && (seen_b > 0))
        else stop_with_failure("Layer 2 on top did not show both its own colour and layer 1");

        write_reg(REG_LAYER_CTRL, 16'h0003);
        check_frame("layer 1 on top", rgb_of(q_val), rgb_of(q_val));

        if (DUT.u_chk.fail_count != 0) begin
            stop_with_failure("A timing or blanking assertion in video_chk failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/ppu_regs.sv
rtl/scroll_layer.sv
rtl/colmix.sv
rtl/video_top.sv
tb/video_chk.sv
tb/tb_video.sv

/* run.sh */
#!/bin/sh
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_video -f verilog.f -o vsim_tb_video
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

# Bound assertions keep running after an error so the testbench can stop the run
./obj_dir/vsim_tb_video +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0
